// ==== design/soc_bus_pkg.sv ====
// ========================================================
// address map and codes for the physical-only data port
// offsets are relative to the 256 MB region of bits 31:28
// ========================================================
package soc_bus_pkg;

    localparam int XLEN     = 32;
    localparam int LINE_W   = 128;
    localparam int CTRL_W   = 3;
    localparam int MTIME_W  = 64;
    localparam int DEV_W    = 4;
    localparam int OFFSET_W = 28;

    // region select on address bits 31:28
    localparam logic [DEV_W-1:0] DEV_DRAM       = 4'h8;
    localparam logic [DEV_W-1:0] DEV_DRAM_ALIAS = 4'h0;
    localparam logic [DEV_W-1:0] DEV_PLIC       = 4'h5;
    localparam logic [DEV_W-1:0] DEV_CLINT      = 4'h6;

    // host mailbox is a single full address
    localparam logic [XLEN-1:0] TOHOST_ADDR = 32'h4000_1000;

    localparam logic [OFFSET_W-1:0] PLIC_CLAIM_OFF    = 28'h020_0004;
    localparam logic [OFFSET_W-1:0] CLINT_MTIMECMP_LO = 28'h000_4000;
    localparam logic [OFFSET_W-1:0] CLINT_MTIMECMP_HI = 28'h000_4004;
    localparam logic [OFFSET_W-1:0] CLINT_MTIME_LO    = 28'h000_bff8;
    localparam logic [OFFSET_W-1:0] CLINT_MTIME_HI    = 28'h000_bffc;

    // source ids 1..N_IRQ, id 0 means no interrupt
    localparam int N_IRQ    = 5;
    localparam int IRQ_ID_W = 3;

    // upper 16 bits of the tohost word
    localparam logic [15:0] CMD_PRINT_CHAR = 16'h0101;
    localparam logic [15:0] CMD_POWER_OFF  = 16'h0002;

    // mip masks, bit 11 and bit 9
    localparam logic [XLEN-1:0] MIP_MEIP = 32'h0000_0800;
    localparam logic [XLEN-1:0] MIP_SEIP = 32'h0000_0200;

    // load/store control, size in bits 1:0
    localparam logic [1:0] LS_BYTE = 2'd0;
    localparam logic [1:0] LS_HALF = 2'd1;
    localparam logic [1:0] LS_WORD = 2'd2;
    // bit index of the unsigned flag
    localparam int LS_UNSIGNED = 2;

endpackage

// ==== design/addr_decode_mux.sv ====
// ========================================================
// unmapped reads complete after one cycle with zero data
// ========================================================
module addr_decode_mux
    import soc_bus_pkg::*;
(
    input  logic                 CLK,
    input  logic                 i_arst_n,
    input  logic [XLEN-1:0]      i_addr,
    input  logic                 i_we,
    input  logic                 i_re,
    input  logic                 i_dram_busy,
    input  logic                 i_dram_rvalid,
    input  logic [XLEN-1:0]      i_load_word,
    input  logic [XLEN-1:0]      i_plic_rdata,
    input  logic [XLEN-1:0]      i_clint_rdata,
    output logic [OFFSET_W-1:0]  o_offset,
    output logic                 o_dram_sel_we,
    output logic                 o_dram_sel_re,
    output logic                 o_plic_re,
    output logic                 o_plic_we,
    output logic                 o_clint_we,
    output logic                 o_tohost_we,
    output logic [XLEN-1:0]      o_rdata,
    output logic                 o_rvalid,
    output logic                 o_busy
);

    logic [DEV_W-1:0] w_dev;
    logic             w_is_dram;
    logic             w_dram_done;
    logic [DEV_W-1:0] r_dev_sel;
    logic             r_dev_rd;
    logic             r_dram_pend;

    assign w_dev     = i_addr[XLEN-1 -: DEV_W];
    assign o_offset  = i_addr[OFFSET_W-1:0];
    assign w_is_dram = (w_dev == DEV_DRAM) || (w_dev == DEV_DRAM_ALIAS);

    // DRAM strobes are held back while the controller is busy
    assign o_dram_sel_we = i_we && w_is_dram && !i_dram_busy;
    assign o_dram_sel_re = i_re && w_is_dram && !i_dram_busy;
    assign o_busy        = w_is_dram && i_dram_busy;

    assign o_plic_re   = i_re && (w_dev == DEV_PLIC);
    assign o_plic_we   = i_we && (w_dev == DEV_PLIC);
    assign o_clint_we  = i_we && (w_dev == DEV_CLINT);
    assign o_tohost_we = i_we && (i_addr == TOHOST_ADDR);

    // device reads return one cycle later, DRAM on rvalid
    always_ff @(posedge CLK or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_dev_sel   <= '0;
            r_dev_rd    <= 1'b0;
            r_dram_pend <= 1'b0;
        end else begin
            r_dev_sel <= w_dev;
            r_dev_rd  <= i_re && !w_is_dram;
            if (o_dram_sel_re) begin
                r_dram_pend <= 1'b1;
            end else if (i_dram_rvalid) begin
                r_dram_pend <= 1'b0;
            end
        end
    end

    assign w_dram_done = r_dram_pend && i_dram_rvalid;
    assign o_rvalid    = w_dram_done || r_dev_rd;

    always_comb begin
        if (w_dram_done) begin
            o_rdata = i_load_word;
        end else begin
            case (r_dev_sel)
                DEV_PLIC:  o_rdata = i_plic_rdata;
                DEV_CLINT: o_rdata = i_clint_rdata;
                default:   o_rdata = '0;
            endcase
        end
    end

endmodule

// ==== design/load_align.sv ====
// ========================================================
// offset and size are taken when the read is issued
// ========================================================
module load_align
    import soc_bus_pkg::*;
(
    input  logic               CLK,
    input  logic               i_arst_n,
    input  logic               i_capture,
    input  logic [3:0]         i_addr_lo,
    input  logic [CTRL_W-1:0]  i_ctrl,
    input  logic [LINE_W-1:0]  i_rline,
    output logic [XLEN-1:0]    o_load_word
);

    logic [3:0]        r_off;
    logic [CTRL_W-1:0] r_ctrl;
    logic [LINE_W-1:0] w_shifted;
    logic [XLEN-1:0]   w_word;
    logic              w_signed;
    logic [XLEN-1:0]   w_ld_byte;
    logic [XLEN-1:0]   w_ld_half;

    always_ff @(posedge CLK or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_off  <= '0;
            r_ctrl <= '0;
        end else if (i_capture) begin
            r_off  <= i_addr_lo;
            r_ctrl <= i_ctrl;
        end
    end

    // byte offset within the 16-byte line
    assign w_shifted = i_rline >> {r_off, 3'b000};
    assign w_word    = w_shifted[XLEN-1:0];
    assign w_signed  = !r_ctrl[LS_UNSIGNED];

    assign w_ld_byte = {{(XLEN - 8){w_word[7] & w_signed}}, w_word[7:0]};
    assign w_ld_half = {{(XLEN - 16){w_word[15] & w_signed}}, w_word[15:0]};

    always_comb begin
        case (r_ctrl[1:0])
            LS_BYTE: o_load_word = w_ld_byte;
            LS_HALF: o_load_word = w_ld_half;
            LS_WORD: o_load_word = w_word;
            // size code 3 is not a legal load, full word returned
            default: o_load_word = w_word;
        endcase
    end

endmodule

// ==== design/plic_core.sv ====
// ========================================================
// single hart, no priorities or enables; lowest id wins
// a completion clears both the pending and the served bit
// ========================================================
module plic_core
    import soc_bus_pkg::*;
(
    input  logic              CLK,
    input  logic              i_arst_n,
    input  logic [N_IRQ-1:0]  i_irq_req,
    input  logic              i_claim,
    input  logic              i_complete,
    input  logic [XLEN-1:0]   i_complete_id,
    input  logic [XLEN-1:0]   i_mip,
    output logic [XLEN-1:0]   o_rdata,
    output logic              o_plic_we,
    output logic [XLEN-1:0]   o_wmip
);

    logic [N_IRQ-1:0]    r_pending;
    logic [N_IRQ-1:0]    r_served;
    logic                r_plic_we;
    logic [XLEN-1:0]     r_rdata;
    logic [N_IRQ-1:0]    w_avail;
    logic [N_IRQ-1:0]    w_claim_hot;
    logic [IRQ_ID_W-1:0] w_claim_id;
    logic [N_IRQ-1:0]    w_done_hot;

    assign w_avail = r_pending & ~r_served;

    // scan from the top so that the lowest id is kept
    always_comb begin
        w_claim_id  = '0;
        w_claim_hot = '0;
        for (int i = N_IRQ - 1; i >= 0; i--) begin
            if (w_avail[i]) begin
                w_claim_id     = IRQ_ID_W'(i + 1);
                w_claim_hot    = '0;
                w_claim_hot[i] = 1'b1;
            end
        end
    end

    // id written on completion, bit i holds id i+1
    always_comb begin
        w_done_hot = '0;
        for (int i = 0; i < N_IRQ; i++) begin
            if (i_complete && (i_complete_id == XLEN'(i + 1))) begin
                w_done_hot[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_pending <= '0;
            r_served  <= '0;
            r_plic_we <= 1'b0;
        end else begin
            r_pending <= (r_pending | i_irq_req) & ~w_done_hot;
            if (i_claim) begin
                r_served <= (r_served | w_claim_hot) & ~w_done_hot;
            end else begin
                r_served <= r_served & ~w_done_hot;
            end
            r_plic_we <= (|i_irq_req) || i_claim || i_complete;
        end
    end

    // zero when nothing is claimable
    always_ff @(posedge CLK) begin
        r_rdata <= i_claim ? {{(XLEN - IRQ_ID_W){1'b0}}, w_claim_id} : '0;
    end

    assign o_rdata   = r_rdata;
    assign o_plic_we = r_plic_we;

    // external interrupt lines follow the unserved pending set
    assign o_wmip = (|w_avail) ? (i_mip | MIP_MEIP | MIP_SEIP)
                               : (i_mip & ~(MIP_MEIP | MIP_SEIP));

endmodule

// ==== design/clint_access.sv ====
// ========================================================
// mtime itself is read only; the core owns both timers
// ========================================================
module clint_access
    import soc_bus_pkg::*;
(
    input  logic                 CLK,
    input  logic                 i_arst_n,
    input  logic [OFFSET_W-1:0]  i_offset,
    input  logic                 i_we,
    input  logic [XLEN-1:0]      i_wdata,
    input  logic [MTIME_W-1:0]   i_mtime,
    input  logic [MTIME_W-1:0]   i_mtimecmp,
    output logic [XLEN-1:0]      o_rdata,
    output logic [MTIME_W-1:0]   o_wmtimecmp,
    output logic                 o_clint_we
);

    logic w_cmp_lo;
    logic w_cmp_hi;

    assign w_cmp_lo = (i_offset == CLINT_MTIMECMP_LO);
    assign w_cmp_hi = (i_offset == CLINT_MTIMECMP_HI);

    // merge the written half into the current compare value
    assign o_wmtimecmp = w_cmp_lo ? {i_mtimecmp[MTIME_W-1:XLEN], i_wdata} :
                         w_cmp_hi ? {i_wdata, i_mtimecmp[XLEN-1:0]} : i_mtimecmp;
    assign o_clint_we  = i_we && (w_cmp_lo || w_cmp_hi);

    always_ff @(posedge CLK or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_rdata <= '0;
        end else begin
            case (i_offset)
                CLINT_MTIME_LO:    o_rdata <= i_mtime[XLEN-1:0];
                CLINT_MTIME_HI:    o_rdata <= i_mtime[MTIME_W-1:XLEN];
                CLINT_MTIMECMP_LO: o_rdata <= i_mtimecmp[XLEN-1:0];
                CLINT_MTIMECMP_HI: o_rdata <= i_mtimecmp[MTIME_W-1:XLEN];
                default:           o_rdata <= '0;
            endcase
        end
    end

endmodule

// ==== design/host_mailbox.sv ====
// ========================================================
// write lands in tohost, the command acts one edge later
// o_finish stays set until the next reset
// ========================================================
module host_mailbox
    import soc_bus_pkg::*;
(
    input  logic             CLK,
    input  logic             i_arst_n,
    input  logic             i_we,
    input  logic [XLEN-1:0]  i_wdata,
    output logic [7:0]       o_uart_data,
    output logic             o_uart_we,
    output logic             o_finish
);

    logic [XLEN-1:0] r_tohost;
    logic            w_is_print;
    logic            w_is_off;

    assign w_is_print = (r_tohost[XLEN-1:16] == CMD_PRINT_CHAR);
    assign w_is_off   = (r_tohost[XLEN-1:16] == CMD_POWER_OFF);

    always_ff @(posedge CLK or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_tohost  <= '0;
            o_uart_we <= 1'b0;
            o_finish  <= 1'b0;
        end else begin
            o_uart_we <= w_is_print;
            if (w_is_off) begin
                o_finish <= 1'b1;
            end
            // a printed char is consumed, so clear the mailbox
            if (i_we) begin
                r_tohost <= i_wdata;
            end else if (w_is_print) begin
                r_tohost <= '0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (w_is_print) begin
            o_uart_data <= r_tohost[7:0];
        end
    end

endmodule

// ==== design/mem_interconnect.sv ====
// ========================================================
// data-port interconnect, physical addresses only
// one DRAM read in flight; requester waits for o_rvalid
// ========================================================
module mem_interconnect
    import soc_bus_pkg::*;
(
    input  logic                CLK,
    input  logic                i_arst_n,
    input  logic [XLEN-1:0]     i_addr,
    input  logic [XLEN-1:0]     i_wdata,
    input  logic [CTRL_W-1:0]   i_ctrl,
    input  logic                i_we,
    input  logic                i_re,
    input  logic                i_dram_busy,
    input  logic                i_dram_rvalid,
    input  logic [LINE_W-1:0]   i_dram_rline,
    input  logic [MTIME_W-1:0]  i_mtime,
    input  logic [MTIME_W-1:0]  i_mtimecmp,
    input  logic [XLEN-1:0]     i_mip,
    input  logic [N_IRQ-1:0]    i_irq_req,
    output logic [XLEN-1:0]     o_rdata,
    output logic                o_rvalid,
    output logic                o_busy,
    output logic [XLEN-1:0]     o_dram_addr,
    output logic [XLEN-1:0]     o_dram_wdata,
    output logic [CTRL_W-1:0]   o_dram_ctrl,
    output logic                o_dram_we,
    output logic                o_dram_re,
    output logic [XLEN-1:0]     o_wmip,
    output logic                o_plic_we,
    output logic [MTIME_W-1:0]  o_wmtimecmp,
    output logic                o_clint_we,
    output logic [7:0]          o_uart_data,
    output logic                o_uart_we,
    output logic                o_finish
);

    logic [OFFSET_W-1:0] w_offset;
    logic                w_plic_rd;
    logic                w_plic_wr;
    logic                w_clint_wr;
    logic                w_tohost_wr;
    logic [XLEN-1:0]     w_load_word;
    logic [XLEN-1:0]     w_plic_rdata;
    logic [XLEN-1:0]     w_clint_rdata;

    // only the claim/complete register of the PLIC is implemented
    logic w_claim;
    logic w_complete;

    assign w_claim    = w_plic_rd && (w_offset == PLIC_CLAIM_OFF);
    assign w_complete = w_plic_wr && (w_offset == PLIC_CLAIM_OFF);

    // DRAM address, data and size pass straight through
    assign o_dram_addr  = i_addr;
    assign o_dram_wdata = i_wdata;
    assign o_dram_ctrl  = i_ctrl;

    addr_decode_mux u_decode (
        .CLK            (CLK),
        .i_arst_n       (i_arst_n),
        .i_addr         (i_addr),
        .i_we           (i_we),
        .i_re           (i_re),
        .i_dram_busy    (i_dram_busy),
        .i_dram_rvalid  (i_dram_rvalid),
        .i_load_word    (w_load_word),
        .i_plic_rdata   (w_plic_rdata),
        .i_clint_rdata  (w_clint_rdata),
        .o_offset       (w_offset),
        .o_dram_sel_we  (o_dram_we),
        .o_dram_sel_re  (o_dram_re),
        .o_plic_re      (w_plic_rd),
        .o_plic_we      (w_plic_wr),
        .o_clint_we     (w_clint_wr),
        .o_tohost_we    (w_tohost_wr),
        .o_rdata        (o_rdata),
        .o_rvalid       (o_rvalid),
        .o_busy         (o_busy)
    );

    load_align u_load_align (
        .CLK            (CLK),
        .i_arst_n       (i_arst_n),
        .i_capture      (o_dram_re),
        .i_addr_lo      (i_addr[3:0]),
        .i_ctrl         (i_ctrl),
        .i_rline        (i_dram_rline),
        .o_load_word    (w_load_word)
    );

    plic_core u_plic (
        .CLK            (CLK),
        .i_arst_n       (i_arst_n),
        .i_irq_req      (i_irq_req),
        .i_claim        (w_claim),
        .i_complete     (w_complete),
        .i_complete_id  (i_wdata),
        .i_mip          (i_mip),
        .o_rdata        (w_plic_rdata),
        .o_plic_we      (o_plic_we),
        .o_wmip         (o_wmip)
    );

    clint_access u_clint (
        .CLK            (CLK),
        .i_arst_n       (i_arst_n),
        .i_offset       (w_offset),
        .i_we           (w_clint_wr),
        .i_wdata        (i_wdata),
        .i_mtime        (i_mtime),
        .i_mtimecmp     (i_mtimecmp),
        .o_rdata        (w_clint_rdata),
        .o_wmtimecmp    (o_wmtimecmp),
        .o_clint_we     (o_clint_we)
    );

    host_mailbox u_mailbox (
        .CLK            (CLK),
        .i_arst_n       (i_arst_n),
        .i_we           (w_tohost_wr),
        .i_wdata        (i_wdata),
        .o_uart_data    (o_uart_data),
        .o_uart_we      (o_uart_we),
        .o_finish       (o_finish)
    );

endmodule

// ==== verification/mem_interconnect_props.sv ====
// ============================================================
// port-level checks, bound into mem_interconnect
// ============================================================
module mem_interconnect_props
    import soc_bus_pkg::*;
(
    input logic            CLK,
    input logic            i_arst_n,
    input logic [XLEN-1:0] i_addr,
    input logic            i_re,
    input logic            i_dram_busy,
    input logic            o_dram_we,
    input logic            o_dram_re,
    input logic            o_uart_we,
    input logic            o_rvalid
);
    timeunit 1ns;
    timeprecision 1ps;

    a_dram_one_strobe: assert property (@(posedge CLK) disable iff (!i_arst_n)
        !(o_dram_we && o_dram_re))
        else $error("DRAM read and write strobes high together");

    // busy holds both strobes back
    a_dram_busy_hold: assert property (@(posedge CLK) disable iff (!i_arst_n)
        i_dram_busy |-> !(o_dram_we || o_dram_re))
        else $error("DRAM strobe raised while the controller is busy");

    a_uart_pulse: assert property (@(posedge CLK) disable iff (!i_arst_n)
        o_uart_we |=> !o_uart_we)
        else $error("uart write strobe longer than one cycle");

    a_plic_read_valid: assert property (@(posedge CLK) disable iff (!i_arst_n)
        (i_re && (i_addr[XLEN-1 -: DEV_W] == DEV_PLIC)) |=> o_rvalid)
        else $error("no read valid one cycle after a PLIC read");

endmodule

// ==== verification/tb_mem_interconnect.sv ====
// ============================================================
// directed tests of the data-port interconnect
// testbench acts as DRAM controller, core and irq sources
// ============================================================
module tb_mem_interconnect
    import soc_bus_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // dram loads need at most about 550 cycles, the other tests under 80
    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [XLEN-1:0] PLIC_CLAIM_ADDR = {DEV_PLIC, PLIC_CLAIM_OFF};

    logic CLK;
    logic i_arst_n;
    logic [XLEN-1:0] i_addr, i_wdata, i_mip, o_rdata, o_dram_addr, o_dram_wdata, o_wmip;
    logic [CTRL_W-1:0] i_ctrl, o_dram_ctrl;
    logic i_we, i_re, i_dram_busy, i_dram_rvalid;
    logic [LINE_W-1:0] i_dram_rline;
    logic [MTIME_W-1:0] i_mtime, i_mtimecmp, o_wmtimecmp;
    logic [N_IRQ-1:0] i_irq_req;
    logic o_rvalid, o_busy, o_dram_we, o_dram_re, o_plic_we, o_clint_we;
    logic [7:0] o_uart_data;
    logic o_uart_we, o_finish;
    logic [31:0] lfsr_state;
    int checks;
    int errors;
    int cycles;

    mem_interconnect u_dut (.*);

    bind mem_interconnect mem_interconnect_props u_props (
        .CLK         (CLK),
        .i_arst_n    (i_arst_n),
        .i_addr      (i_addr),
        .i_re        (i_re),
        .i_dram_busy (i_dram_busy),
        .o_dram_we   (o_dram_we),
        .o_dram_re   (o_dram_re),
        .o_uart_we   (o_uart_we),
        .o_rvalid    (o_rvalid)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_word(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // byte lanes of the line, then sign fill
    function automatic logic [31:0] expect_load(input logic [LINE_W-1:0] line, input int off,
                                                input logic [CTRL_W-1:0] ctrl);
        logic [31:0] raw;
        int nbytes;
        raw = '0;
        nbytes = (ctrl[1:0] == LS_BYTE) ? 1 : (ctrl[1:0] == LS_HALF) ? 2 : 4;
        for (int b = 0; b < nbytes; b++) begin
            raw[8*b +: 8] = line[8*(off+b) +: 8];
        end
        if (!ctrl[LS_UNSIGNED] && raw[8*nbytes-1]) begin
            for (int b = nbytes; b < 4; b++) begin
                raw[8*b +: 8] = 8'hff;
            end
        end
        return raw;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic settle();
        #2;
    endtask

    task automatic end_test(input string name, input int err0);
        $display("test %s finished with %0d error(s)", name, errors - err0);
    endtask

    task automatic dev_read(input logic [31:0] addr, input logic [31:0] exp, input string name);
        next_cycle();
        i_addr = addr;
        i_re = 1'b1;
        next_cycle();
        i_re = 1'b0;
        settle();
        check("o_rvalid", 64'(o_rvalid), 64'd1);
        check(name, 64'(o_rdata), 64'(exp));
    endtask

    task automatic dev_write(input logic [31:0] addr, input logic [31:0] data);
        next_cycle();
        i_addr = addr;
        i_wdata = data;
        i_we = 1'b1;
        next_cycle();
        i_we = 1'b0;
    endtask

    task automatic reset_values();
        int err0;
        err0 = errors;
        settle();
        check("o_rvalid", 64'(o_rvalid), 64'd0);
        check("o_dram_we", 64'(o_dram_we), 64'd0);
        check("o_dram_re", 64'(o_dram_re), 64'd0);
        check("o_uart_we", 64'(o_uart_we), 64'd0);
        check("o_plic_we", 64'(o_plic_we), 64'd0);
        check("o_clint_we", 64'(o_clint_we), 64'd0);
        check("o_finish", 64'(o_finish), 64'd0);
        end_test("reset", err0);
    endtask

    task automatic dram_loads();
        int err0;
        int nbytes;
        int delay;
        logic [LINE_W-1:0] line;
        logic [CTRL_W-1:0] ctrl;
        logic [31:0] base;
        logic [31:0] u;
        err0 = errors;
        for (int l = 0; l < 2; l++) begin
            line = {rand_word(32), rand_word(32), rand_word(32), rand_word(32)};
            // second pass goes through the alias region
            base = (l == 0) ? 32'h8000_0100 : 32'h0000_0100;
            for (int sz = 0; sz < 3; sz++) begin
                nbytes = 1 << sz;
                for (int off = 0; off + nbytes <= 16; off++) begin
                    u = rand_word(1);
                    ctrl = {u[0], 2'(sz)};
                    delay = 1 + int'(rand_word(2));
                    next_cycle();
                    i_addr = base | 32'(off);
                    i_ctrl = ctrl;
                    i_re = 1'b1;
                    settle();
                    check("o_dram_re", 64'(o_dram_re), 64'd1);
                    next_cycle();
                    i_re = 1'b0;
                    repeat (delay - 1) next_cycle();
                    i_dram_rvalid = 1'b1;
                    i_dram_rline = line;
                    settle();
                    check("o_rvalid", 64'(o_rvalid), 64'd1);
                    check("o_rdata", 64'(o_rdata), 64'(expect_load(line, off, ctrl)));
                    next_cycle();
                    i_dram_rvalid = 1'b0;
                end
            end
        end
        end_test("dram_load", err0);
    endtask

    task automatic dram_writes();
        int err0;
        logic [31:0] data;
        err0 = errors;
        data = rand_word(32);
        next_cycle();
        i_addr = 32'h8000_0040;
        i_wdata = data;
        i_ctrl = {1'b0, LS_WORD};
        i_we = 1'b1;
        settle();
        check("o_dram_we", 64'(o_dram_we), 64'd1);
        check("o_busy", 64'(o_busy), 64'd0);
        check("o_dram_addr", 64'(o_dram_addr), 64'h8000_0040);
        check("o_dram_wdata", 64'(o_dram_wdata), 64'(data));
        check("o_dram_ctrl", 64'(o_dram_ctrl), 64'({1'b0, LS_WORD}));
        next_cycle();
        i_addr = 32'h0000_0044;
        i_dram_busy = 1'b1;
        // request held for two busy cycles
        repeat (2) begin
            settle();
            check("o_dram_we", 64'(o_dram_we), 64'd0);
            check("o_busy", 64'(o_busy), 64'd1);
            next_cycle();
        end
        i_dram_busy = 1'b0;
        settle();
        check("o_dram_we", 64'(o_dram_we), 64'd1);
        check("o_dram_addr", 64'(o_dram_addr), 64'h0000_0044);
        next_cycle();
        i_we = 1'b0;
        settle();
        check("o_dram_we", 64'(o_dram_we), 64'd0);
        end_test("dram_write", err0);
    endtask

    task automatic plic_claims();
        int err0;
        err0 = errors;
        next_cycle();
        // core already holds MEIP, SEIP is clear
        i_mip = 32'h0000_0880;
        i_irq_req = 5'b00101;
        next_cycle();
        i_irq_req = '0;
        settle();
        check("o_plic_we", 64'(o_plic_we), 64'd1);
        check("o_wmip", 64'(o_wmip), 64'h0000_0a80);
        dev_read(PLIC_CLAIM_ADDR, 32'd1, "o_rdata");
        check("o_wmip", 64'(o_wmip), 64'h0000_0a80);
        dev_read(PLIC_CLAIM_ADDR, 32'd3, "o_rdata");
        check("o_wmip", 64'(o_wmip), 64'h0000_0080);
        dev_read(PLIC_CLAIM_ADDR, 32'd0, "o_rdata");
        dev_write(PLIC_CLAIM_ADDR, 32'd1);
        dev_write(PLIC_CLAIM_ADDR, 32'd3);
        settle();
        check("o_wmip", 64'(o_wmip), 64'h0000_0080);
        // id 1 can be raised and claimed again once completed
        next_cycle();
        i_irq_req = 5'b00001;
        next_cycle();
        i_irq_req = '0;
        settle();
        check("o_wmip", 64'(o_wmip), 64'h0000_0a80);
        dev_read(PLIC_CLAIM_ADDR, 32'd1, "o_rdata");
        dev_write(PLIC_CLAIM_ADDR, 32'd1);
        settle();
        check("o_wmip", 64'(o_wmip), 64'h0000_0080);
        end_test("plic", err0);
    endtask

    task automatic clint_timer();
        int err0;
        logic [31:0] data;
        err0 = errors;
        data = rand_word(32);
        next_cycle();
        i_mtime = {rand_word(32), rand_word(32)};
        i_mtimecmp = {rand_word(32), rand_word(32)};
        i_addr = {DEV_CLINT, CLINT_MTIMECMP_LO};
        i_wdata = data;
        i_we = 1'b1;
        settle();
        check("o_clint_we", 64'(o_clint_we), 64'd1);
        check("o_wmtimecmp", o_wmtimecmp,
              (i_mtimecmp & 64'hffff_ffff_0000_0000) | 64'(data));
        next_cycle();
        i_we = 1'b0;
        settle();
        check("o_clint_we", 64'(o_clint_we), 64'd0);
        dev_read({DEV_CLINT, CLINT_MTIME_HI}, i_mtime[63:32], "o_rdata");
        end_test("clint", err0);
    endtask

    task automatic mailbox_cmds();
        int err0;
        logic [31:0] ch;
        err0 = errors;
        ch = rand_word(8);
        next_cycle();
        i_addr = TOHOST_ADDR;
        i_wdata = {CMD_PRINT_CHAR, 8'h00, ch[7:0]};
        i_we = 1'b1;
        // pulse expected in the third cycle only
        for (int c = 0; c < 4; c++) begin
            settle();
            check("o_uart_we", 64'(o_uart_we), 64'(c == 2));
            if (c == 2) begin
                check("o_uart_data", 64'(o_uart_data), 64'(ch[7:0]));
            end
            next_cycle();
            i_we = 1'b0;
        end
        i_wdata = {CMD_POWER_OFF, 16'h0001};
        i_we = 1'b1;
        for (int c = 0; c < 5; c++) begin
            settle();
            check("o_finish", 64'(o_finish), 64'(c >= 2));
            next_cycle();
            i_we = 1'b0;
        end
        end_test("mailbox", err0);
    endtask

    initial begin
        lfsr_state = 32'd82575;
        checks = 0;
        errors = 0;
        cycles = 0;
        i_arst_n = 1'b0;
        i_addr = '0;
        i_wdata = '0;
        i_ctrl = '0;
        i_we = 1'b0;
        i_re = 1'b0;
        i_dram_busy = 1'b0;
        i_dram_rvalid = 1'b0;
        i_dram_rline = '0;
        i_mtime = '0;
        i_mtimecmp = '0;
        i_mip = '0;
        i_irq_req = '0;
        repeat (3) @(posedge CLK);
        #1;
        i_arst_n = 1'b1;
        reset_values();
        dram_loads();
        dram_writes();
        plic_claims();
        clint_timer();
        mailbox_cmds();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
design/soc_bus_pkg.sv
design/addr_decode_mux.sv
design/load_align.sv
design/plic_core.sv
design/clint_access.sv
design/host_mailbox.sv
design/mem_interconnect.sv
verification/mem_interconnect_props.sv
verification/tb_mem_interconnect.sv

// ==== Makefile ====
TOP := tb_mem_interconnect

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

obj_dir/V$(TOP): verilog.f design/*.sv verification/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
	    --top-module $(TOP) -f verilog.f

lint:
	verilator --lint-only --timing --assert -Wall --timescale 1ns/1ps \
	    --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir
